//--- Makefile
VERILATOR  ?= verilator
TOP        := issue_tb
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+verilog
+incdir+tests
verilog/issue_pkg.sv
verilog/inst_queue.sv
verilog/inst_decoder.sv
verilog/issue_ctrl.sv
verilog/issue_latch.sv
verilog/issue_top.sv
tests/issue_tb.sv

//--- tests/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// entries held by the dut queue, oldest first
logic [31:0] mq_pc[$];
logic [31:0] mq_inst[$];
logic        mq_ds_pending;

function automatic op_class_e ref_class(input logic [31:0] inst);
    op_class_e cls;
    cls = op_invalid;
    case (inst[31:26])
        6'h00: begin
            case (inst[5:0])
                6'h21, 6'h23, 6'h24, 6'h25, 6'h2a: cls = op_alu;
                6'h08: cls = op_jump;
                6'h10, 6'h12, 6'h18: cls = op_hilo;
                default: cls = op_invalid;
            endcase
        end
        6'h09, 6'h0d, 6'h0f: cls = op_alu;
        6'h23, 6'h2b: cls = op_mem;
        6'h04, 6'h05: cls = op_branch;
        6'h02, 6'h03: cls = op_jump;
        // mfc0 and mtc0 only
        6'h10: begin
            if (inst[25:21] == 5'd0 || inst[25:21] == 5'd4) begin
                cls = op_cop0;
            end
        end
        default: cls = op_invalid;
    endcase
    return cls;
endfunction

function automatic logic [4:0] ref_dst(input logic [31:0] inst);
    logic [4:0] dst;
    dst = 5'd0;
    case (inst[31:26])
        6'h00: begin
            case (inst[5:0])
                6'h21, 6'h23, 6'h24, 6'h25, 6'h2a, 6'h10, 6'h12: dst = inst[15:11];
                default: dst = 5'd0;
            endcase
        end
        6'h09, 6'h0d, 6'h0f, 6'h23: dst = inst[20:16];
        6'h03: dst = 5'd31;
        6'h10: begin
            if (inst[25:21] == 5'd0) begin
                dst = inst[20:16];
            end
        end
        default: dst = 5'd0;
    endcase
    return dst;
endfunction

function automatic logic is_ctl(input op_class_e cls);
    return (cls == op_branch) || (cls == op_jump);
endfunction

// how many of the two oldest entries leave this cycle, stall low
function automatic int pick_count();
    op_class_e   c1;
    op_class_e   c2;
    logic [4:0]  d1;
    logic [31:0] inst_2;
    logic        raw;
    if (mq_inst.size() == 0) begin
        return 0;
    end
    c1 = ref_class(mq_inst[0]);
    if (mq_inst.size() < 2) begin
        // a lone branch waits for its delay slot
        return is_ctl(c1) ? 0 : 1;
    end
    inst_2 = mq_inst[1];
    c2     = ref_class(inst_2);
    d1     = ref_dst(mq_inst[0]);
    raw    = (d1 != 5'd0) && ((d1 == inst_2[25:21]) || (d1 == inst_2[20:16]));
    // misaligned pc in either slot splits the pair
    if (mq_ds_pending || raw || (c2 != op_alu) || (c1 == op_cop0)
        || (mq_pc[0][1:0] != 2'b00) || (mq_pc[1][1:0] != 2'b00)) begin
        return 1;
    end
    return 2;
endfunction

task automatic retire(input int n);
    logic ctl;
    ctl = is_ctl(ref_class(mq_inst[0]));
    mq_ds_pending = ctl && (n == 1);
    repeat (n) begin
        void'(mq_pc.pop_front());
        void'(mq_inst.pop_front());
    end
endtask

`endif

//--- tests/issue_tb.sv
`default_nettype none

`include "issue_params.svh"

module issue_tb
    import issue_pkg::*;
();

    localparam int NUM_PUSH       = 2000;
    localparam int TIMEOUT_CYCLES = 4 * NUM_PUSH;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic [31:0]       in_pc;
    logic [31:0]       in_inst;
    logic              stall;
    logic [1:0]        credit_return;
    logic              out_valid_1;
    logic              out_valid_2;
    logic [31:0]       out_pc_1;
    logic [31:0]       out_pc_2;
    logic [31:0]       out_inst_1;
    logic [31:0]       out_inst_2;
    op_class_e         out_class_1;
    op_class_e         out_class_2;
    logic [4:0]        out_w_dst_1;
    logic [4:0]        out_w_dst_2;
    logic              out_w_ena_1;
    logic              out_w_ena_2;
    logic              out_ds_1;
    logic              out_ds_2;
    logic              out_adel_1;
    logic              out_adel_2;

    integer      seed;
    int          credits;
    int          pushed;
    int          issued;
    int          total_ret;
    int          errors;
    int          checks;
    int          cycle_cnt;
    logic [31:0] next_pc;
    logic        finished;

    // expected latch contents after the coming edge
    logic        exp_v1;
    logic        exp_v2;
    logic [31:0] exp_pc1;
    logic [31:0] exp_pc2;
    logic [31:0] exp_inst1;
    logic [31:0] exp_inst2;
    logic        exp_ds1;
    logic        exp_ds2;
    logic [1:0]  exp_cr;
    logic        hold_check;
    logic [151:0] held_bits;

    `include "issue_model.svh"

    issue_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .stall         (stall),
        .credit_return (credit_return),
        .out_valid_1   (out_valid_1),
        .out_valid_2   (out_valid_2),
        .out_pc_1      (out_pc_1),
        .out_pc_2      (out_pc_2),
        .out_inst_1    (out_inst_1),
        .out_inst_2    (out_inst_2),
        .out_class_1   (out_class_1),
        .out_class_2   (out_class_2),
        .out_w_dst_1   (out_w_dst_1),
        .out_w_dst_2   (out_w_dst_2),
        .out_w_ena_1   (out_w_ena_1),
        .out_w_ena_2   (out_w_ena_2),
        .out_ds_1      (out_ds_1),
        .out_ds_2      (out_ds_2),
        .out_adel_1    (out_adel_1),
        .out_adel_2    (out_adel_2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] inst;
        // few registers so hazards show up often
        rs  = 5'(rand_below(8));
        rt  = 5'(rand_below(8));
        rd  = 5'(rand_below(8));
        imm = 16'(rand_below(65536));
        case (rand_below(23))
            0: inst = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1: inst = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2: inst = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3: inst = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4: inst = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            5: inst = {6'h09, rs, rt, imm};
            6: inst = {6'h0d, rs, rt, imm};
            7: inst = {6'h0f, 5'd0, rt, imm};
            8: inst = {6'h23, rs, rt, imm};
            9: inst = {6'h2b, rs, rt, imm};
            10: inst = {6'h04, rs, rt, imm};
            11: inst = {6'h05, rs, rt, imm};
            12: inst = {6'h02, rs, rt, imm};
            13: inst = {6'h03, rs, rt, imm};
            14: inst = {6'h00, rs, 15'd0, 6'h08};
            15: inst = {6'h00, rs, rt, 10'd0, 6'h18};
            16: inst = {6'h00, 10'd0, rd, 5'd0, 6'h10};
            17: inst = {6'h00, 10'd0, rd, 5'd0, 6'h12};
            18: inst = {6'h10, 5'd0, rt, rd, 11'd0};
            19: inst = {6'h10, 5'd4, rt, rd, 11'd0};
            20: inst = {6'h00, rs, rt, rd, 5'd0, 6'h3f};
            21: inst = {6'h10, 5'd1, rt, rd, 11'd0};
            default: inst = {6'h3f, rs, rt, imm};
        endcase
        return inst;
    endfunction

    function automatic logic [151:0] out_bits();
        return {out_valid_1, out_valid_2, out_pc_1, out_pc_2, out_inst_1, out_inst_2,
                out_class_1, out_class_2, out_w_dst_1, out_w_dst_2, out_w_ena_1,
                out_w_ena_2, out_ds_1, out_ds_2, out_adel_1, out_adel_2};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
    endtask

    task automatic check_slot(input int slot, input logic [31:0] e_pc,
                              input logic [31:0] e_inst, input logic e_ds,
                              input logic [31:0] pc, input logic [31:0] inst,
                              input op_class_e cls, input logic [4:0] dst,
                              input logic wena, input logic ds, input logic adel);
        op_class_e  e_cls;
        logic [4:0] e_dst;
        e_cls = ref_class(e_inst);
        e_dst = ref_dst(e_inst);
        if (pc !== e_pc) begin
            report_mismatch($sformatf("out_pc_%0d", slot), e_pc, pc);
        end
        if (inst !== e_inst) begin
            report_mismatch($sformatf("out_inst_%0d", slot), e_inst, inst);
        end
        if (cls !== e_cls) begin
            report_mismatch($sformatf("out_class_%0d", slot), 32'(e_cls), 32'(cls));
        end
        if (dst !== e_dst) begin
            report_mismatch($sformatf("out_w_dst_%0d", slot), 32'(e_dst), 32'(dst));
        end
        if (wena !== (e_dst != 5'd0)) begin
            report_mismatch($sformatf("out_w_ena_%0d", slot), 32'(e_dst != 5'd0), 32'(wena));
        end
        if (adel !== (e_pc[1:0] != 2'b00)) begin
            report_mismatch($sformatf("out_adel_%0d", slot), 32'(e_pc[1:0] != 2'b00),
                            32'(adel));
        end
        if (ds !== e_ds) begin
            report_mismatch($sformatf("out_ds_%0d", slot), 32'(e_ds), 32'(ds));
        end
    endtask

    task automatic check_outputs();
        checks++;
        if (out_valid_1 !== exp_v1) begin
            report_mismatch("out_valid_1", 32'(exp_v1), 32'(out_valid_1));
        end
        if (out_valid_2 !== exp_v2) begin
            report_mismatch("out_valid_2", 32'(exp_v2), 32'(out_valid_2));
        end
        if (credit_return !== exp_cr) begin
            report_mismatch("credit_return", 32'(exp_cr), 32'(credit_return));
        end
        if (hold_check && (out_bits() !== held_bits)) begin
            errors++;
            $display("CHECK FAILED t=%0t out_ports exp=%h got=%h", $time, held_bits,
                     out_bits());
        end
        if (exp_v1) begin
            check_slot(1, exp_pc1, exp_inst1, exp_ds1, out_pc_1, out_inst_1, out_class_1,
                       out_w_dst_1, out_w_ena_1, out_ds_1, out_adel_1);
        end
        if (exp_v2) begin
            check_slot(2, exp_pc2, exp_inst2, exp_ds2, out_pc_2, out_inst_2, out_class_2,
                       out_w_dst_2, out_w_ena_2, out_ds_2, out_adel_2);
        end
    endtask

    // inputs for the next edge, and what the latch should hold after it
    task automatic drive_cycle();
        int          n;
        logic        push;
        logic [31:0] pc;
        logic [31:0] inst;
        held_bits = out_bits();
        stall     = 1'b0;
        in_valid  = 1'b0;
        push      = 1'b0;
        pc        = next_pc;
        inst      = 32'd0;
        if (pushed < NUM_PUSH) begin
            stall = (rand_below(4) == 0);
            push  = (credits > 0) && (rand_below(10) < 7);
        end
        hold_check = stall;
        if (push) begin
            inst = rand_inst();
            if (pushed == NUM_PUSH - 1) begin
                // plain addu last, nothing left waiting for a delay slot
                inst = {6'h00, 5'd0, 5'd0, 5'd1, 5'd0, 6'h21};
            end else if (rand_below(16) == 0) begin
                pc = pc | 32'(rand_below(3) + 1);
            end
            next_pc  = next_pc + 32'd4;
            in_valid = 1'b1;
            in_pc    = pc;
            in_inst  = inst;
            credits--;
            pushed++;
        end
        if (stall) begin
            exp_cr = 2'd0;
        end else begin
            n      = pick_count();
            exp_v1 = (n > 0);
            exp_v2 = (n == 2);
            exp_cr = 2'(n);
            if (n > 0) begin
                exp_pc1   = mq_pc[0];
                exp_inst1 = mq_inst[0];
                exp_ds1   = mq_ds_pending;
            end
            if (n == 2) begin
                exp_pc2   = mq_pc[1];
                exp_inst2 = mq_inst[1];
                exp_ds2   = is_ctl(ref_class(mq_inst[0]));
            end
            if (n > 0) begin
                retire(n);
            end
            issued += n;
        end
        // a push lands behind whatever is popped at the same edge
        if (push) begin
            mq_pc.push_back(pc);
            mq_inst.push_back(inst);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the queue did not drain", cycle_cnt);
        $display("checks %0d, errors %0d, pushed %0d, issued %0d", checks, errors, pushed,
                 issued);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed          = 98388;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = 32'd0;
        in_inst       = 32'd0;
        stall         = 1'b0;
        credits       = `IQ_DEPTH;
        pushed        = 0;
        issued        = 0;
        total_ret     = 0;
        errors        = 0;
        checks        = 0;
        next_pc       = 32'h0000_1000;
        mq_ds_pending = 1'b0;
        exp_v1        = 1'b0;
        exp_v2        = 1'b0;
        exp_pc1       = 32'd0;
        exp_pc2       = 32'd0;
        exp_inst1     = 32'd0;
        exp_inst2     = 32'd0;
        exp_ds1       = 1'b0;
        exp_ds2       = 1'b0;
        exp_cr        = 2'd0;
        hold_check    = 1'b0;
        held_bits     = '0;
        finished      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!finished) begin
            check_outputs();
            credits   += int'(credit_return);
            total_ret += int'(credit_return);
            if (credits > `IQ_DEPTH) begin
                errors++;
                $display("credit counter at %0d is above the queue depth", credits);
            end
            if ((pushed == NUM_PUSH) && (mq_inst.size() == 0)) begin
                finished = 1'b1;
            end else begin
                drive_cycle();
                @(posedge clk);
                #1;
            end
        end
        if (credits != `IQ_DEPTH) begin
            errors++;
            $display("sender holds %0d credits after the drain instead of %0d", credits,
                     `IQ_DEPTH);
        end
        if (total_ret != NUM_PUSH) begin
            errors++;
            $display("%0d credits came back for %0d pushes", total_ret, NUM_PUSH);
        end
        $display("checks %0d, errors %0d, pushed %0d, issued %0d", checks, errors, pushed,
                 issued);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`default_nettype none

`include "issue_params.svh"

module inst_decoder
    import issue_pkg::*;
(
    input  wire [`XLEN-1:0]   pc,
    input  wire [`XLEN-1:0]   inst,
    output op_class_e         op_class,
    output logic [`REG_W-1:0] rs,
    output logic [`REG_W-1:0] rt,
    output logic [`REG_W-1:0] w_dst,
    output logic              w_ena,
    output logic              adel
);

    // cop0 move direction, rs field
    localparam logic [4:0] cop0_mf = 5'b00000;
    localparam logic [4:0] cop0_mt = 5'b00100;

    logic [`REG_W-1:0] rd;

    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    always_comb begin
        op_class = op_invalid;
        w_dst    = '0;
        case (inst[31:26])
            opc_special: begin
                case (inst[5:0])
                    fn_addu, fn_subu, fn_and, fn_or, fn_slt: begin
                        op_class = op_alu;
                        w_dst    = rd;
                    end
                    fn_jr: op_class = op_jump;
                    fn_mult: op_class = op_hilo;
                    fn_mfhi, fn_mflo: begin
                        op_class = op_hilo;
                        w_dst    = rd;
                    end
                    default: op_class = op_invalid;
                endcase
            end
            opc_addiu, opc_ori, opc_lui: begin
                op_class = op_alu;
                w_dst    = rt;
            end
            opc_lw: begin
                op_class = op_mem;
                w_dst    = rt;
            end
            opc_sw: op_class = op_mem;
            opc_beq, opc_bne: op_class = op_branch;
            opc_j: op_class = op_jump;
            opc_jal: begin
                op_class = op_jump;
                // link register
                w_dst    = `REG_W'(31);
            end
            opc_cop0: begin
                if (inst[25:21] == cop0_mf) begin
                    op_class = op_cop0;
                    w_dst    = rt;
                end else if (inst[25:21] == cop0_mt) begin
                    op_class = op_cop0;
                end
            end
            default: op_class = op_invalid;
        endcase
    end

    // writes to r0 are dropped
    assign w_ena = (w_dst != '0);
    assign adel  = (pc[1:0] != 2'b00);

endmodule

`default_nettype wire

//--- verilog/inst_queue.sv
`default_nettype none

`include "issue_params.svh"

module inst_queue
    import issue_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              in_valid,
    input  wire [`XLEN-1:0]  in_pc,
    input  wire [`XLEN-1:0]  in_inst,
    input  wire issue_sel_e  issue_sel,
    output logic             head_valid_1,
    output logic             head_valid_2,
    output logic [`XLEN-1:0] head_pc_1,
    output logic [`XLEN-1:0] head_pc_2,
    output logic [`XLEN-1:0] head_inst_1,
    output logic [`XLEN-1:0] head_inst_2,
    output logic [1:0]       credit_return
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    logic [`XLEN-1:0] pc_mem   [`IQ_DEPTH];
    logic [`XLEN-1:0] inst_mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [PTR_W:0]   count;
    logic [1:0]       pop_cnt;

    always_comb begin
        case (issue_sel)
            sel_one: pop_cnt = 2'd1;
            sel_two: pop_cnt = 2'd2;
            default: pop_cnt = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 2'd0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr        <= rd_ptr + PTR_W'(pop_cnt);
            count         <= count + (PTR_W + 1)'(in_valid) - (PTR_W + 1)'(pop_cnt);
            // one credit back per entry that left last cycle
            credit_return <= pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pc_mem[wr_ptr]   <= in_pc;
            inst_mem[wr_ptr] <= in_inst;
        end
    end

    // two oldest entries
    assign rd_ptr_nxt   = rd_ptr + 1'b1;
    assign head_valid_1 = (count != '0);
    assign head_valid_2 = (count > (PTR_W + 1)'(1));
    assign head_pc_1    = pc_mem[rd_ptr];
    assign head_inst_1  = inst_mem[rd_ptr];
    assign head_pc_2    = pc_mem[rd_ptr_nxt];
    assign head_inst_2  = inst_mem[rd_ptr_nxt];

    // sender must hold a credit, so a full queue never sees a push
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (count < (PTR_W + 1)'(`IQ_DEPTH)));

    a_no_over_pop: assert property (@(posedge clk) disable iff (rst)
        (PTR_W + 1)'(pop_cnt) <= count);

endmodule

`default_nettype wire

//--- verilog/issue_ctrl.sv
`default_nettype none

`include "issue_params.svh"

module issue_ctrl
    import issue_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              head_valid_1,
    input  wire              head_valid_2,
    input  wire              latch_ready,
    input  wire op_class_e   class_1,
    input  wire op_class_e   class_2,
    input  wire [`REG_W-1:0] rs_2,
    input  wire [`REG_W-1:0] rt_2,
    input  wire [`REG_W-1:0] w_dst_1,
    input  wire              w_ena_1,
    input  wire              adel_1,
    input  wire              adel_2,
    output issue_sel_e       issue_sel,
    output logic             ds_1,
    output logic             ds_2
);

    logic ds_pending;
    logic ctl_1;
    logic raw_hazard;
    logic slot_1_ok;
    logic pair_ok;

    assign ctl_1      = (class_1 == op_branch) || (class_1 == op_jump);
    assign raw_hazard = w_ena_1 && ((w_dst_1 == rs_2) || (w_dst_1 == rt_2));

    // a branch waits until its delay slot is in the queue
    assign slot_1_ok = latch_ready && head_valid_1 && (!ctl_1 || head_valid_2);

    // only plain alu ops ride in slot 2
    // a faulting pc in either slot keeps the pair apart
    assign pair_ok = head_valid_2
                     && !ds_pending
                     && !raw_hazard
                     && (class_2 == op_alu)
                     && (class_1 != op_cop0)
                     && !adel_1
                     && !adel_2;

    always_comb begin
        if (!slot_1_ok) begin
            issue_sel = sel_none;
        end else if (pair_ok) begin
            issue_sel = sel_two;
        end else begin
            issue_sel = sel_one;
        end
    end

    // branch left alone, its delay slot is the next thing to issue
    always_ff @(posedge clk) begin
        if (rst) begin
            ds_pending <= 1'b0;
        end else if (issue_sel != sel_none) begin
            ds_pending <= ctl_1 && (issue_sel == sel_one);
        end
    end

    assign ds_1 = ds_pending;
    assign ds_2 = ctl_1 && (issue_sel == sel_two);

    a_two_needs_head_2: assert property (@(posedge clk) disable iff (rst)
        (issue_sel == sel_two) |-> head_valid_2);

endmodule

`default_nettype wire

//--- verilog/issue_latch.sv
`default_nettype none

`include "issue_params.svh"

module issue_latch
    import issue_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               stall,
    input  wire issue_sel_e   issue_sel,
    input  wire [`XLEN-1:0]   head_pc_1,
    input  wire [`XLEN-1:0]   head_pc_2,
    input  wire [`XLEN-1:0]   head_inst_1,
    input  wire [`XLEN-1:0]   head_inst_2,
    input  wire op_class_e    class_1,
    input  wire op_class_e    class_2,
    input  wire [`REG_W-1:0]  w_dst_1,
    input  wire [`REG_W-1:0]  w_dst_2,
    input  wire               w_ena_1,
    input  wire               w_ena_2,
    input  wire               ds_1,
    input  wire               ds_2,
    input  wire               adel_1,
    input  wire               adel_2,
    output logic              latch_ready,
    output logic              out_valid_1,
    output logic              out_valid_2,
    output logic [`XLEN-1:0]  out_pc_1,
    output logic [`XLEN-1:0]  out_pc_2,
    output logic [`XLEN-1:0]  out_inst_1,
    output logic [`XLEN-1:0]  out_inst_2,
    output op_class_e         out_class_1,
    output op_class_e         out_class_2,
    output logic [`REG_W-1:0] out_w_dst_1,
    output logic [`REG_W-1:0] out_w_dst_2,
    output logic              out_w_ena_1,
    output logic              out_w_ena_2,
    output logic              out_ds_1,
    output logic              out_ds_2,
    output logic              out_adel_1,
    output logic              out_adel_2
);

    assign latch_ready = !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_1 <= 1'b0;
            out_valid_2 <= 1'b0;
        end else if (!stall) begin
            out_valid_1 <= (issue_sel != sel_none);
            out_valid_2 <= (issue_sel == sel_two);
        end
    end

    // payload only moves for the slots that actually issue
    always_ff @(posedge clk) begin
        if (!stall && (issue_sel != sel_none)) begin
            out_pc_1    <= head_pc_1;
            out_inst_1  <= head_inst_1;
            out_class_1 <= class_1;
            out_w_dst_1 <= w_dst_1;
            out_w_ena_1 <= w_ena_1;
            out_ds_1    <= ds_1;
            out_adel_1  <= adel_1;
        end
        if (!stall && (issue_sel == sel_two)) begin
            out_pc_2    <= head_pc_2;
            out_inst_2  <= head_inst_2;
            out_class_2 <= class_2;
            out_w_dst_2 <= w_dst_2;
            out_w_ena_2 <= w_ena_2;
            out_ds_2    <= ds_2;
            out_adel_2  <= adel_2;
        end
    end

    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        out_valid_2 |-> out_valid_1);

endmodule

`default_nettype wire

//--- verilog/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// queue entries, also the sender's starting credit count
// keep a power of two, the queue pointers wrap naturally
`define IQ_DEPTH 8

// pc and instruction word width
`define XLEN 32

// gpr index width
`define REG_W 5

`endif

//--- verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // decoded instruction class
    typedef enum logic [2:0] {
        op_alu,
        op_mem,
        op_branch,
        op_jump,
        op_hilo,
        op_cop0,
        op_invalid
    } op_class_e;

    // how many queue entries leave this cycle
    typedef enum logic [1:0] {
        sel_none,
        sel_one,
        sel_two
    } issue_sel_e;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        opc_special = 6'b000000,
        opc_j       = 6'b000010,
        opc_jal     = 6'b000011,
        opc_beq     = 6'b000100,
        opc_bne     = 6'b000101,
        opc_addiu   = 6'b001001,
        opc_ori     = 6'b001101,
        opc_lui     = 6'b001111,
        opc_cop0    = 6'b010000,
        opc_lw      = 6'b100011,
        opc_sw      = 6'b101011
    } opcode_e;

    // funct field of special, inst[5:0]
    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_mfhi = 6'b010000,
        fn_mflo = 6'b010010,
        fn_mult = 6'b011000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_slt  = 6'b101010
    } funct_e;

endpackage

`default_nettype wire

//--- verilog/issue_top.sv
`default_nettype none

`include "issue_params.svh"

module issue_top
    import issue_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               in_valid,
    input  wire [`XLEN-1:0]   in_pc,
    input  wire [`XLEN-1:0]   in_inst,
    input  wire               stall,
    output logic [1:0]        credit_return,
    output logic              out_valid_1,
    output logic              out_valid_2,
    output logic [`XLEN-1:0]  out_pc_1,
    output logic [`XLEN-1:0]  out_pc_2,
    output logic [`XLEN-1:0]  out_inst_1,
    output logic [`XLEN-1:0]  out_inst_2,
    output op_class_e         out_class_1,
    output op_class_e         out_class_2,
    output logic [`REG_W-1:0] out_w_dst_1,
    output logic [`REG_W-1:0] out_w_dst_2,
    output logic              out_w_ena_1,
    output logic              out_w_ena_2,
    output logic              out_ds_1,
    output logic              out_ds_2,
    output logic              out_adel_1,
    output logic              out_adel_2
);

    wire                head_valid_1;
    wire                head_valid_2;
    wire [`XLEN-1:0]    head_pc_1;
    wire [`XLEN-1:0]    head_pc_2;
    wire [`XLEN-1:0]    head_inst_1;
    wire [`XLEN-1:0]    head_inst_2;
    wire op_class_e     class_1;
    wire op_class_e     class_2;
    wire [`REG_W-1:0]   rs_2;
    wire [`REG_W-1:0]   rt_2;
    wire [`REG_W-1:0]   w_dst_1;
    wire [`REG_W-1:0]   w_dst_2;
    wire                w_ena_1;
    wire                w_ena_2;
    wire                adel_1;
    wire                adel_2;
    wire                ds_1;
    wire                ds_2;
    wire                latch_ready;
    wire issue_sel_e    issue_sel;

    inst_queue i_queue (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .issue_sel     (issue_sel),
        .head_valid_1  (head_valid_1),
        .head_valid_2  (head_valid_2),
        .head_pc_1     (head_pc_1),
        .head_pc_2     (head_pc_2),
        .head_inst_1   (head_inst_1),
        .head_inst_2   (head_inst_2),
        .credit_return (credit_return)
    );

    // slot 1 sources never feed a hazard check
    inst_decoder i_dec_1 (
        .pc       (head_pc_1),
        .inst     (head_inst_1),
        .op_class (class_1),
        .rs       (),
        .rt       (),
        .w_dst    (w_dst_1),
        .w_ena    (w_ena_1),
        .adel     (adel_1)
    );

    inst_decoder i_dec_2 (
        .pc       (head_pc_2),
        .inst     (head_inst_2),
        .op_class (class_2),
        .rs       (rs_2),
        .rt       (rt_2),
        .w_dst    (w_dst_2),
        .w_ena    (w_ena_2),
        .adel     (adel_2)
    );

    issue_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .head_valid_1 (head_valid_1),
        .head_valid_2 (head_valid_2),
        .latch_ready  (latch_ready),
        .class_1      (class_1),
        .class_2      (class_2),
        .rs_2         (rs_2),
        .rt_2         (rt_2),
        .w_dst_1      (w_dst_1),
        .w_ena_1      (w_ena_1),
        .adel_1       (adel_1),
        .adel_2       (adel_2),
        .issue_sel    (issue_sel),
        .ds_1         (ds_1),
        .ds_2         (ds_2)
    );

    issue_latch i_latch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .issue_sel   (issue_sel),
        .head_pc_1   (head_pc_1),
        .head_pc_2   (head_pc_2),
        .head_inst_1 (head_inst_1),
        .head_inst_2 (head_inst_2),
        .class_1     (class_1),
        .class_2     (class_2),
        .w_dst_1     (w_dst_1),
        .w_dst_2     (w_dst_2),
        .w_ena_1     (w_ena_1),
        .w_ena_2     (w_ena_2),
        .ds_1        (ds_1),
        .ds_2        (ds_2),
        .adel_1      (adel_1),
        .adel_2      (adel_2),
        .latch_ready (latch_ready),
        .out_valid_1 (out_valid_1),
        .out_valid_2 (out_valid_2),
        .out_pc_1    (out_pc_1),
        .out_pc_2    (out_pc_2),
        .out_inst_1  (out_inst_1),
        .out_inst_2  (out_inst_2),
        .out_class_1 (out_class_1),
        .out_class_2 (out_class_2),
        .out_w_dst_1 (out_w_dst_1),
        .out_w_dst_2 (out_w_dst_2),
        .out_w_ena_1 (out_w_ena_1),
        .out_w_ena_2 (out_w_ena_2),
        .out_ds_1    (out_ds_1),
        .out_ds_2    (out_ds_2),
        .out_adel_1  (out_adel_1),
        .out_adel_2  (out_adel_2)
    );

endmodule

`default_nettype wire
